// File: cpu_top.f
+incdir+source
source/isa_pkg.sv
source/cpu_ctrl_pkg.sv
source/alu.sv
source/reg_file.sv
source/cpu_datapath.sv
source/cpu_sequencer.sv
source/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

// File: Bender.yml
package:
  name: accum_cpu

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/cpu_ctrl_pkg.sv
      - source/alu.sv
      - source/reg_file.sv
      - source/cpu_datapath.sv
      - source/cpu_sequencer.sv
      - source/cpu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/cpu_asserts.sv
      - sim/cpu_tb.sv

// File: sim/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb import isa_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT = 4000;  // 6 tests x 40 instr x 10 cycles, plus reset and margin
  localparam int HALT_LIMIT  = 400;   // 40 instructions at up to 10 cycles
  localparam logic [7:0] BAD_ADDR = 8'hE0;  // Only a wrong jump lands here
  localparam logic [7:0] BAD_VAL  = 8'hEE;

  localparam logic [7:0] OP_NOP = {CLS_CTRL, GRP_MISC, MISC_NOP};
  localparam logic [7:0] OP_OUT = {CLS_CTRL, GRP_MISC, MISC_OUT};
  localparam logic [7:0] OP_HLT = {CLS_CTRL, GRP_MISC, MISC_HLT};

  logic                   clk;
  logic                   reset;
  logic                   mem_rd;
  logic [`CPU_ADDR_W-1:0] mem_addr;
  logic [`CPU_DATA_W-1:0] mem_rdata;
  logic                   mem_ready;
  logic                   out_valid;
  logic [`CPU_DATA_W-1:0] out_data;
  logic                   halted;

  logic [7:0] mem [256];
  logic [7:0] out_q [$];  // out_data values seen with out_valid
  logic [7:0] exp_q [$];
  logic [7:0] wr_ptr;
  integer     seed = 56957;
  int         wait_left = -1;
  int         errors = 0;
  int         test_err0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         cycles = 0;

  cpu_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .mem_rd    (mem_rd),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Memory with 0 to 3 wait cycles
  // ----------------------------------------
  always @(negedge clk) begin
    if (mem_rd) begin
      if (wait_left < 0) begin
        wait_left = $unsigned($random(seed)) % 4;  // New request
      end
      if (wait_left == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[mem_addr];
        wait_left = -1;
      end else begin
        mem_ready = 1'b0;
        wait_left = wait_left - 1;
      end
    end else begin
      mem_ready = 1'b0;
      wait_left = -1;
    end
  end

  always @(negedge clk) begin
    if (out_valid) begin
      out_q.push_back(out_data);
      assert (!halted) else begin
        $display("out_valid pulsed while the CPU was halted");
        errors++;
      end
    end
  end

  function automatic int errs_now();
    return errors + dut0.asserts0.fail_count;
  endfunction

  // Reference {carry, result} from the ALU rules
  function automatic logic [8:0] alu_ref(input alu_op_e op, input logic [7:0] a,
                                         input logic [7:0] b, input logic cin);
    logic [8:0] r;
    case (op)
      ADD:     r = {1'b0, a} + {1'b0, b};
      ADC:     r = {1'b0, a} + {1'b0, b} + 9'(cin);
      SUB:     r = {a < b, 8'(a - b)};  // Borrow
      INC:     r = {a == 8'hFF, 8'(a + 8'd1)};
      DEC:     r = {a == 8'h00, 8'(a - 8'd1)};
      AND:     r = {1'b0, a & b};
      OR:      r = {1'b0, a | b};
      default: r = {1'b0, a ^ b};
    endcase
    return r;
  endfunction

  function automatic logic [7:0] ldi_op(input reg_id_t dst);
    return {CLS_CTRL, GRP_LDI, dst};
  endfunction

  function automatic logic [7:0] mov_op(input reg_id_t src, input reg_id_t dst);
    return {CLS_MOV, src, dst};
  endfunction

  function automatic logic [7:0] alu_opcode(input alu_op_e op);
    return {CLS_ALU, op, 3'b000};
  endfunction

  function automatic logic [7:0] jmp_op(input jump_cond_e cond);
    return {CLS_CTRL, GRP_JMP, cond};
  endfunction

  // ----------------------------------------
  // Program building
  // ----------------------------------------
  task automatic emit(input logic [7:0] data);
    mem[wr_ptr] = data;
    wr_ptr = wr_ptr + 8'd1;
  endtask

  task automatic emit_ldi(input reg_id_t dst, input logic [7:0] value);
    emit(ldi_op(dst));
    emit(value);
  endtask

  // Jump over a block that would print BAD_VAL
  task automatic emit_skip(input jump_cond_e cond);
    emit(jmp_op(cond));
    emit(wr_ptr + 8'd4);
    emit_ldi(REG_A, BAD_VAL);
    emit(OP_OUT);
  endtask

  task automatic prepare_test();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'h5A;
    end
    wr_ptr = BAD_ADDR;
    emit_ldi(REG_A, BAD_VAL);
    emit(OP_OUT);
    emit(OP_HLT);
    wr_ptr = `CPU_RESET_PC;
    exp_q.delete();
    test_err0 = errs_now();
  endtask

  // ADD with carry out, both carry jumps, then ADC
  task automatic build_carry_program();
    logic [8:0] r;
    emit_ldi(REG_A, 8'hF0);
    emit_ldi(REG_B, 8'h25);
    emit(alu_opcode(ADD));
    emit(OP_OUT);
    r = alu_ref(ADD, 8'hF0, 8'h25, 1'b0);
    exp_q.push_back(r[7:0]);
    emit(jmp_op(JNC));
    emit(BAD_ADDR);
    emit_skip(JC);
    emit(alu_opcode(ADC));
    emit(OP_OUT);
    r = alu_ref(ADC, r[7:0], 8'h25, r[8]);
    exp_q.push_back(r[7:0]);
    emit(OP_HLT);
  endtask

  // ----------------------------------------
  // Test steps
  // ----------------------------------------
  task automatic start_cpu();
    reset = 1'b1;
    repeat (8) @(negedge clk);
    assert (!mem_rd && !out_valid && !halted && mem_addr == `CPU_RESET_PC) else begin
      $display("ERROR mem_rd, out_valid, halted, mem_addr in reset: ",
               "expected 0x0 0x0 0x0 0x%02h, got 0x%0h 0x%0h 0x%0h 0x%02h",
               `CPU_RESET_PC, mem_rd, out_valid, halted, mem_addr);
      errors++;
    end
    out_q.delete();
    reset = 1'b0;
  endtask

  task automatic wait_halt(input string name);
    int n;
    n = 0;
    while (!halted && n < HALT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    assert (halted) else begin
      $display("%s: the CPU did not halt within %0d cycles", name, HALT_LIMIT);
      errors++;
    end
    repeat (10) @(negedge clk);  // No out_valid may follow HLT
  endtask

  task automatic check_outputs(input string name);
    assert (out_q.size() == exp_q.size()) else begin
      $display("%s: expected %0d outputs but saw %0d", name, exp_q.size(), out_q.size());
      errors++;
    end
    for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
      assert (out_q[i] == exp_q[i]) else begin
        $display("ERROR out_data #%0d: expected 0x%02h, got 0x%02h", i, exp_q[i], out_q[i]);
        errors++;
      end
    end
    tests_run++;
    if (errs_now() == test_err0) begin
      $display("%s: ok, %0d outputs", name, out_q.size());
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errs_now() - test_err0);
    end
  endtask

  task automatic run_test(input string name);
    start_cpu();
    wait_halt(name);
    check_outputs(name);
  endtask

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, a test never finished", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    logic [7:0] vals [8];
    logic [7:0] a;
    logic [7:0] b;
    logic [8:0] r;
    int         n;

    reset     = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;

    // LDI into every register, then MOV each one to A
    prepare_test();
    for (int i = 0; i < 8; i++) begin
      vals[i] = 8'($random(seed));
      emit_ldi(reg_id_t'(i), vals[i]);
    end
    for (int i = 0; i < 8; i++) begin
      emit(mov_op(reg_id_t'(i), REG_A));
      emit(OP_OUT);
      exp_q.push_back(vals[i]);
    end
    emit(OP_HLT);
    run_test("ldi_mov");

    // Operands chosen so that every operation gives its own result
    prepare_test();
    a = 8'hC5;
    b = 8'h6A;
    emit_ldi(REG_B, b);
    for (int k = 0; k < 7; k++) begin  // ADD up to XOR
      emit_ldi(REG_A, a);
      emit(alu_opcode(alu_op_e'(k)));
      emit(OP_OUT);
      r = alu_ref(alu_op_e'(k), a, b, 1'b0);
      exp_q.push_back(r[7:0]);
    end
    emit(OP_HLT);
    run_test("alu_ops");

    prepare_test();
    build_carry_program();
    run_test("carry");

    // Zero flag set by SUB, then cleared by DEC
    prepare_test();
    a = 8'h3C;
    emit_ldi(REG_A, a);
    emit_ldi(REG_B, a);
    emit(alu_opcode(SUB));
    r = alu_ref(SUB, a, a, 1'b0);
    emit(jmp_op(JNZ));
    emit(BAD_ADDR);
    emit_skip(JZ);
    emit(OP_OUT);
    exp_q.push_back(r[7:0]);
    emit_ldi(REG_A, 8'h05);
    emit(alu_opcode(DEC));
    r = alu_ref(DEC, 8'h05, a, 1'b0);
    emit(jmp_op(JZ));
    emit(BAD_ADDR);
    emit_skip(JNZ);
    emit(OP_OUT);
    exp_q.push_back(r[7:0]);
    emit(OP_HLT);
    run_test("zero_jumps");

    prepare_test();
    emit(OP_NOP);
    emit({2'b11, 6'b000000});            // Unused class
    emit({CLS_CTRL, GRP_MISC, 3'b001});  // Unused sub-code
    emit_ldi(REG_A, 8'h42);
    emit(OP_OUT);
    exp_q.push_back(8'h42);
    emit(OP_NOP);
    emit_skip(JMP);
    emit(OP_HLT);
    run_test("nop_halt");

    // Reset after the first output, then a full rerun
    prepare_test();
    build_carry_program();
    start_cpu();
    n = 0;
    while (out_q.size() < 1 && n < HALT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    run_test("mid_reset");

    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut0.asserts0.fail_count);
    if (errs_now() == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/cpu_asserts.sv
`include "cpu_settings.svh"

module cpu_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   mem_rd,
  input logic [`CPU_ADDR_W-1:0] mem_addr,
  input logic                   mem_ready,
  input logic                   out_valid,
  input logic                   halted
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Failed assertions so far

  // ----------------------------------------
  // Memory read port
  // ----------------------------------------
  read_held: assert property (@(posedge clk) disable iff (reset)
    mem_rd && !mem_ready |=> mem_rd && $stable(mem_addr))
    else begin
      $error("Read request dropped or mem_addr moved before mem_ready");
      fail_count++;
    end

  no_read_when_halted: assert property (@(posedge clk) disable iff (reset)
    halted |-> !mem_rd)
    else begin
      $error("mem_rd high while halted");
      fail_count++;
    end

  // ----------------------------------------
  // Output port and halt
  // ----------------------------------------
  single_pulse: assert property (@(posedge clk) disable iff (reset)
    out_valid |=> !out_valid)
    else begin
      $error("out_valid high for two cycles in a row");
      fail_count++;
    end

  halt_sticks: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted)
    else begin
      $error("halted fell without reset");
      fail_count++;
    end

endmodule

bind cpu_top cpu_asserts asserts0 (.*);

// File: source/cpu_top.sv
`include "cpu_settings.svh"

module cpu_top import cpu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  output logic                   mem_rd,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  input  logic                   mem_ready,
  output logic                   out_valid,
  output logic [`CPU_DATA_W-1:0] out_data,
  output logic                   halted
);

  dp_ctrl_t   ctrl;    // Strobes for the execute cycle
  dp_status_t status;  // Flags back to jump decode

  cpu_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .status    (status),
    .mem_rd    (mem_rd),
    .mem_addr  (mem_addr),
    .ctrl      (ctrl),
    .halted    (halted)
  );

  cpu_datapath u_dp (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .status    (status),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// File: source/cpu_sequencer.sv
`include "cpu_settings.svh"

module cpu_sequencer import isa_pkg::*, cpu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CPU_DATA_W-1:0] mem_rdata,
  input  logic                   mem_ready,
  input  dp_status_t             status,
  output logic                   mem_rd,
  output logic [`CPU_ADDR_W-1:0] mem_addr,
  output dp_ctrl_t               ctrl,
  output logic                   halted
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_IMM,
    S_EXEC,
    S_HALT
  } seq_state_e;

  seq_state_e             state;
  logic [`CPU_ADDR_W-1:0] pc;
  instr_u                 ir;
  logic [`CPU_DATA_W-1:0] imm_q;
  instr_u                 fetched;    // Opcode arriving from memory
  logic                   needs_imm;
  logic                   cond_met;
  logic                   jump_taken;
  logic                   exec_halt;

  // ----------------------------------------
  // Memory port
  // ----------------------------------------
  assign mem_rd   = (state == S_FETCH) || (state == S_IMM);
  assign mem_addr = pc;
  assign halted   = (state == S_HALT);

  // LDI and JMP carry a second byte
  assign fetched.raw = mem_rdata;
  assign needs_imm   = (fetched.f.cls == CLS_CTRL) &&
                       ((fetched.f.hi == GRP_LDI) || (fetched.f.hi == GRP_JMP));

  always_comb begin
    case (jump_cond_e'(ir.f.lo))
      JMP:     cond_met = 1'b1;
      JZ:      cond_met = status.zero;
      JNZ:     cond_met = !status.zero;
      JC:      cond_met = status.carry;
      JNC:     cond_met = !status.carry;
      default: cond_met = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Execute decode
  // ----------------------------------------
  always_comb begin
    ctrl        = '0;
    ctrl.imm    = imm_q;
    ctrl.alu_op = alu_op_e'(ir.f.hi);
    ctrl.rd_reg = ir.f.hi;
    ctrl.wb_reg = ir.f.lo;
    jump_taken  = 1'b0;
    exec_halt   = 1'b0;

    if (state == S_EXEC) begin
      case (ir.f.cls)
        CLS_ALU: begin
          ctrl.wb_en    = 1'b1;
          ctrl.wb_src   = WB_ALU;
          ctrl.wb_reg   = REG_A;  // Result always lands in A
          ctrl.flags_en = 1'b1;
        end
        CLS_MOV: begin
          ctrl.wb_en  = 1'b1;
          ctrl.wb_src = WB_REG;
        end
        CLS_CTRL: begin
          case (ctrl_group_e'(ir.f.hi))
            GRP_MISC: begin
              case (misc_op_e'(ir.f.lo))
                MISC_NOP: exec_halt = 1'b0;
                MISC_OUT: ctrl.out_en = 1'b1;
                MISC_HLT: exec_halt = 1'b1;
                default:  exec_halt = 1'b0;  // Unused sub-codes
              endcase
            end
            GRP_LDI: begin
              ctrl.wb_en  = 1'b1;
              ctrl.wb_src = WB_IMM;
            end
            GRP_JMP: jump_taken = cond_met;
            default: jump_taken = 1'b0;
          endcase
        end
        default: jump_taken = 1'b0;  // Class 3 runs as NOP
      endcase
    end
  end

  // ----------------------------------------
  // State, PC and instruction register
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
      pc    <= `CPU_RESET_PC;
      ir    <= '0;
    end else begin
      case (state)
        S_IDLE: state <= S_FETCH;  // First read one cycle after reset
        S_FETCH: begin
          if (mem_ready) begin
            ir    <= fetched;
            pc    <= pc + 1'b1;
            state <= needs_imm ? S_IMM : S_EXEC;
          end
        end
        S_IMM: begin
          if (mem_ready) begin
            pc    <= pc + 1'b1;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (jump_taken) begin
            pc <= imm_q;
          end
          state <= exec_halt ? S_HALT : S_FETCH;
        end
        default: state <= S_HALT;  // Left only through reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IMM) && mem_ready) begin
      imm_q <= mem_rdata;
    end
  end

endmodule

// File: source/cpu_datapath.sv
`include "cpu_settings.svh"

module cpu_datapath import cpu_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  dp_ctrl_t               ctrl,
  output dp_status_t             status,
  output logic                   out_valid,
  output logic [`CPU_DATA_W-1:0] out_data
);

  logic [`CPU_DATA_W-1:0] wb_data;
  logic [`CPU_DATA_W-1:0] rd_data;
  logic [`CPU_DATA_W-1:0] reg_a;
  logic [`CPU_DATA_W-1:0] reg_b;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic                   alu_zero;
  logic                   alu_carry;

  reg_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (ctrl.wb_en),
    .wr_reg  (ctrl.wb_reg),
    .wr_data (wb_data),
    .rd_reg  (ctrl.rd_reg),
    .rd_data (rd_data),
    .reg_a   (reg_a),
    .reg_b   (reg_b)
  );

  alu u_alu (
    .a        (reg_a),
    .b        (reg_b),
    .op       (ctrl.alu_op),
    .carry_in (status.carry),  // Used by ADC only
    .result   (alu_result),
    .zero     (alu_zero),
    .carry    (alu_carry)
  );

  always_comb begin
    case (ctrl.wb_src)
      WB_IMM:  wb_data = ctrl.imm;
      WB_REG:  wb_data = rd_data;
      default: wb_data = alu_result;
    endcase
  end

  // ----------------------------------------
  // Flags and output port
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      status    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (ctrl.flags_en) begin
        status.zero  <= alu_zero;
        status.carry <= alu_carry;
      end
      out_valid <= ctrl.out_en;  // One-cycle pulse
    end
  end

  // Holds A as it was at the last OUT
  always_ff @(posedge clk) begin
    if (ctrl.out_en) begin
      out_data <= reg_a;
    end
  end

endmodule

// File: source/reg_file.sv
`include "cpu_settings.svh"

module reg_file import isa_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   wr_en,
  input  reg_id_t                wr_reg,
  input  logic [`CPU_DATA_W-1:0] wr_data,
  input  reg_id_t                rd_reg,
  output logic [`CPU_DATA_W-1:0] rd_data,
  output logic [`CPU_DATA_W-1:0] reg_a,
  output logic [`CPU_DATA_W-1:0] reg_b
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_reg] <= wr_data;
    end
  end

  // ----------------------------------------
  // Read ports
  // ----------------------------------------
  assign rd_data = regs[rd_reg];  // MOV source
  assign reg_a   = regs[REG_A];   // ALU operand and output port
  assign reg_b   = regs[REG_B];

endmodule

// File: source/alu.sv
`include "cpu_settings.svh"

module alu import isa_pkg::*; (
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  alu_op_e                op,
  input  logic                   carry_in,
  output logic [`CPU_DATA_W-1:0] result,
  output logic                   zero,
  output logic                   carry
);

  // One extra bit holds carry or borrow
  logic [`CPU_DATA_W:0] ext_a;
  logic [`CPU_DATA_W:0] ext_b;
  logic [`CPU_DATA_W:0] ext_r;

  assign ext_a = {1'b0, a};
  assign ext_b = {1'b0, b};

  always_comb begin
    case (op)
      ADD:     ext_r = ext_a + ext_b;
      ADC:     ext_r = ext_a + ext_b + {{`CPU_DATA_W{1'b0}}, carry_in};
      SUB:     ext_r = ext_a - ext_b;  // Top bit set when a < b
      INC:     ext_r = ext_a + 1'b1;   // Carry on FF -> 00
      DEC:     ext_r = ext_a - 1'b1;   // Carry on 00 -> FF
      AND:     ext_r = {1'b0, a & b};
      OR:      ext_r = {1'b0, a | b};
      XOR:     ext_r = {1'b0, a ^ b};
      default: ext_r = ext_a;
    endcase
  end

  assign result = ext_r[`CPU_DATA_W-1:0];
  assign carry  = ext_r[`CPU_DATA_W];
  assign zero   = (result == '0);

endmodule

// File: source/cpu_ctrl_pkg.sv
`include "cpu_settings.svh"

package cpu_ctrl_pkg;
  import isa_pkg::*;

  // Write-back source in the datapath
  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_REG
  } wb_src_e;

  // Sequencer to datapath, one-cycle strobes
  typedef struct packed {
    logic                   wb_en;
    wb_src_e                wb_src;
    reg_id_t                wb_reg;
    reg_id_t                rd_reg;   // MOV source
    alu_op_e                alu_op;
    logic                   flags_en;
    logic                   out_en;
    logic [`CPU_DATA_W-1:0] imm;
  } dp_ctrl_t;

  // Datapath to sequencer, current flags
  typedef struct packed {
    logic zero;
    logic carry;
  } dp_status_t;

endpackage

// File: source/isa_pkg.sv
`include "cpu_settings.svh"

package isa_pkg;

  // ----------------------------------------
  // Opcode layout  cc_hhh_lll
  // ----------------------------------------
  typedef enum logic [1:0] {
    CLS_CTRL = 2'b00,
    CLS_ALU  = 2'b01,
    CLS_MOV  = 2'b10  // 2'b11 is unused and runs as NOP
  } instr_class_e;

  // Upper field of the control class
  typedef enum logic [2:0] {
    GRP_MISC = 3'b000,
    GRP_LDI  = 3'b010,  // Lower field is the destination
    GRP_JMP  = 3'b011   // Lower field is the condition
  } ctrl_group_e;

  // Lower field within GRP_MISC
  typedef enum logic [2:0] {
    MISC_NOP = 3'b000,
    MISC_OUT = 3'b011,
    MISC_HLT = 3'b101
  } misc_op_e;

  typedef enum logic [2:0] {
    ADD, SUB, INC, DEC, AND, OR, XOR, ADC
  } alu_op_e;

  typedef enum logic [2:0] {
    JMP, JZ, JNZ, JC, JNC
  } jump_cond_e;

  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_id_t;

  localparam reg_id_t REG_A = reg_id_t'(0);
  localparam reg_id_t REG_B = reg_id_t'(1);

  typedef struct packed {
    instr_class_e cls;
    logic [2:0]   hi;  // Group, ALU op or MOV source
    logic [2:0]   lo;  // Sub-code, condition or destination
  } instr_fields_t;

  // Same byte seen as fields or as the raw opcode
  typedef union packed {
    instr_fields_t f;
    logic [7:0]    raw;
  } instr_u;

endpackage

// File: source/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ----------------------------------------
// Core widths
// ----------------------------------------

// Data word carried by registers, ALU and output port
`define CPU_DATA_W 8

// Program memory address
`define CPU_ADDR_W 8

// General purpose registers, A is index 0 and B is index 1
`define CPU_NUM_REGS 8

// First fetch address after reset
`define CPU_RESET_PC 8'h00

`endif
